// File: Makefile
VERILATOR ?= verilator
TOP       := tb_source
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := ALL CHECKS PASSED
VFLAGS    := --binary --timing --assert --top-module $(TOP) -f $(FILELIST)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/tb_source.sv
// ======================================================================
// source testbench
// preloads the bank with a byte pattern, runs a table of strided read
// jobs with optional stream stalls and preload collisions, and checks
// every beat, the stall hold, the done pulse and ignored mid-job starts
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_source;

  import stream_pkg::*;

  localparam int NJOBS = 11;

  typedef struct packed {
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] stride;
    logic [LEN_W-1:0]  len;
    logic              stall;   // random stream back-pressure
    logic              coll;    // random preload collisions
  } job_t;

  logic               clk_i = 1'b0;
  logic               rst_ni;
  logic               start_i;
  logic [ADDR_W-1:0]  base_i;
  logic [ADDR_W-1:0]  stride_i;
  logic [LEN_W-1:0]   len_i;
  logic               ready_start_o;
  logic               done_o;
  logic               stream_valid_o;
  logic [DATA_W-1:0]  stream_data_o;
  logic               stream_ready_i;
  logic               mem_we_i;
  logic [WORD_AW-1:0] mem_waddr_i;
  logic [DATA_W-1:0]  mem_wdata_i;

  job_t        jobs [NJOBS];
  logic [15:0] lfsr;
  int          n_checks = 0;
  int          n_errors = 0;
  int          jobs_run = 0;
  int          cycle_cnt = 0;
  int          timeout_limit = 0;
  logic        jobs_running = 1'b0;

  source_top dut (.*);

  always #10 clk_i = ~clk_i;

  // memory image, byte b holds low byte of 7b + 3
  function automatic logic [7:0] byte_at(input int b);
    return 8'(b * 7 + 3);
  endfunction

  // little-endian beat starting at byte address a
  function automatic logic [31:0] expect_beat(input int a);
    return {byte_at(a + 3), byte_at(a + 2), byte_at(a + 1), byte_at(a)};
  endfunction

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_bit(output logic b);
    lfsr = lfsr_step(lfsr);
    b = lfsr[0];
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    assert (got == exp) else begin
      n_errors++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic fill_table();
    // base, stride, len, stall, coll
    jobs[0]  = '{10'd0,    10'd4,  8'd16, 1'b0, 1'b0};
    jobs[1]  = '{10'd64,   10'd4,  8'd24, 1'b0, 1'b0};
    jobs[2]  = '{10'd161,  10'd5,  8'd12, 1'b0, 1'b0};   // offset 1
    jobs[3]  = '{10'd258,  10'd6,  8'd10, 1'b0, 1'b0};   // offset 2
    jobs[4]  = '{10'd323,  10'd7,  8'd16, 1'b0, 1'b0};   // offset 3
    jobs[5]  = '{10'd400,  10'd4,  8'd20, 1'b1, 1'b0};
    jobs[6]  = '{10'd481,  10'd9,  8'd16, 1'b1, 1'b1};
    jobs[7]  = '{10'd622,  10'd3,  8'd24, 1'b0, 1'b1};
    jobs[8]  = '{10'd700,  10'd13, 8'd20, 1'b1, 1'b1};
    jobs[9]  = '{10'd1003, 10'd1,  8'd8,  1'b1, 1'b1};
    jobs[10] = '{10'd5,    10'd2,  8'd1,  1'b1, 1'b1};
  endtask

  task automatic drive_ready(input logic stall);
    logic b1;
    logic b2;
    stream_ready_i = 1'b1;
    if (stall) begin
      draw_bit(b1);
      draw_bit(b2);
      stream_ready_i = ~(b1 & b2);   // low one cycle in four
    end
  endtask

  // rewrite a random word with its own value, steals the bank grant
  task automatic drive_collision(input logic en);
    logic       b1;
    logic       b2;
    logic [7:0] wa;
    mem_we_i = 1'b0;
    if (en) begin
      draw_bit(b1);
      draw_bit(b2);
      if (b1 & b2) begin
        for (int i = 0; i < 8; i++) begin
          draw_bit(b1);
          wa[i] = b1;
        end
        mem_we_i    = 1'b1;
        mem_waddr_i = wa;
        mem_wdata_i = expect_beat(4 * int'(wa));
      end
    end
  endtask

  task automatic run_job(input int j);
    int          beat_idx;
    int          n_done;
    int          cyc;
    logic        held;
    logic [31:0] held_data;
    beat_idx = 0;
    n_done   = 0;
    cyc      = 0;
    held     = 1'b0;
    @(negedge clk_i);
    while (!ready_start_o) @(negedge clk_i);
    start_i        = 1'b1;
    base_i         = jobs[j].base;
    stride_i       = jobs[j].stride;
    len_i          = jobs[j].len;
    stream_ready_i = 1'b1;
    mem_we_i       = 1'b0;
    while (n_done == 0) begin
      @(negedge clk_i);
      cyc++;
      start_i = 1'b0;
      if (cyc == 3) begin
        check_value($sformatf("job %0d ready_start mid-job", j), 32'(ready_start_o), 32'd0);
        start_i = 1'b1;              // busy engine, must be dropped
        base_i  = ~jobs[j].base;
      end
      drive_ready(jobs[j].stall);
      drive_collision(jobs[j].coll);
      #1;
      if (held) begin
        check_value($sformatf("job %0d valid under stall", j), 32'(stream_valid_o), 32'd1);
        check_value($sformatf("job %0d data under stall", j), stream_data_o, held_data);
      end
      if (stream_valid_o && stream_ready_i) begin
        check_value($sformatf("job %0d beat %0d", j, beat_idx), stream_data_o,
                    expect_beat(int'(jobs[j].base) + beat_idx * int'(jobs[j].stride)));
        beat_idx++;
      end
      held      = stream_valid_o & ~stream_ready_i;
      held_data = stream_data_o;
      if (done_o) begin
        n_done++;
        check_value($sformatf("job %0d beats at done", j), 32'(beat_idx), 32'(jobs[j].len));
      end
    end
    for (int t = 0; t < 3; t++) begin   // engine must stay quiet
      @(negedge clk_i);
      start_i        = 1'b0;
      stream_ready_i = 1'b1;
      mem_we_i       = 1'b0;
      #1;
      if (done_o) n_done++;
      check_value($sformatf("job %0d ready_start after done", j), 32'(ready_start_o), 32'd1);
      check_value($sformatf("job %0d valid after done", j), 32'(stream_valid_o), 32'd0);
    end
    check_value($sformatf("job %0d done pulses", j), 32'(n_done), 32'd1);
    jobs_run++;
  endtask

  task automatic report_counts();
    $display("jobs: %0d, checks: %0d, errors: %0d", jobs_run, n_checks, n_errors);
  endtask

  always @(posedge clk_i) begin
    if (jobs_running) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= timeout_limit) begin
        $display("timeout: the jobs did not finish within %0d cycles", timeout_limit);
        report_counts();
        $display("CHECKS FAILED");
        $finish;
      end
    end
  end

  initial begin
    int total;
    rst_ni         = 1'b0;
    start_i        = 1'b0;
    base_i         = '0;
    stride_i       = '0;
    len_i          = '0;
    stream_ready_i = 1'b1;
    mem_we_i       = 1'b0;
    mem_waddr_i    = '0;
    mem_wdata_i    = '0;
    lfsr           = 16'd39701;
    total          = 0;
    fill_table();
    for (int j = 0; j < NJOBS; j++) total += int'(jobs[j].len);
    timeout_limit = 8 * total + 200;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    for (int w = 0; w < MEM_WORDS; w++) begin   // preload the whole bank
      @(negedge clk_i);
      mem_we_i    = 1'b1;
      mem_waddr_i = WORD_AW'(w);
      mem_wdata_i = expect_beat(4 * w);
    end
    @(negedge clk_i);
    mem_we_i     = 1'b0;
    jobs_running = 1'b1;
    for (int j = 0; j < NJOBS; j++) run_job(j);
    report_counts();
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/addr_gen.sv
// ======================================================================
// address generator
// walks base, base + stride, ... for len beats and offers one byte
// address per cycle, flagging the final one
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module addr_gen (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          start_i,
  input  logic                          en_i,
  input  logic                          clear_i,
  input  logic [stream_pkg::ADDR_W-1:0] base_i,
  input  logic [stream_pkg::ADDR_W-1:0] stride_i,
  input  logic [stream_pkg::LEN_W-1:0]  len_i,
  output logic [stream_pkg::ADDR_W-1:0] addr_o,
  output logic                          addr_valid_o,
  output logic                          last_o,
  input  logic                          addr_ready_i
);

  import stream_pkg::*;

  logic [ADDR_W-1:0] addr_q;
  logic [ADDR_W-1:0] stride_q;
  logic [LEN_W-1:0]  left_q;     // addresses still to hand out
  logic              active_q;
  logic              step;

  assign step = en_i & active_q & addr_ready_i;

  assign addr_o       = addr_q;
  assign addr_valid_o = active_q;
  assign last_o       = active_q & (left_q == LEN_W'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      left_q   <= '0;
    end else if (clear_i) begin
      active_q <= 1'b0;
      left_q   <= '0;
    end else if (en_i && start_i) begin
      active_q <= (len_i != '0);
      left_q   <= len_i;
    end else if (step) begin
      left_q <= left_q - LEN_W'(1);
      if (last_o) begin
        active_q <= 1'b0;   // final address taken
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (en_i && start_i) begin
      addr_q   <= base_i;
      stride_q <= stride_i;
    end else if (step) begin
      addr_q <= addr_q + stride_q;
    end
  end

  // a new run only opens once the previous one is closed
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (start_i && en_i) |-> !addr_valid_o)
    else $error("start while an address run is still open");

endmodule

`default_nettype wire

// File: logic/source_top.sv
// ======================================================================
// source top level
// the streamer and its scratchpad bank, with job, stream and
// preload ports brought out
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module source_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // job
  input  logic                           start_i,
  input  logic [stream_pkg::ADDR_W-1:0]  base_i,
  input  logic [stream_pkg::ADDR_W-1:0]  stride_i,
  input  logic [stream_pkg::LEN_W-1:0]   len_i,
  output logic                           ready_start_o,
  output logic                           done_o,
  // output stream
  output logic                           stream_valid_o,
  output logic [stream_pkg::DATA_W-1:0]  stream_data_o,
  input  logic                           stream_ready_i,
  // preload
  input  logic                           mem_we_i,
  input  logic [stream_pkg::WORD_AW-1:0] mem_waddr_i,
  input  logic [stream_pkg::DATA_W-1:0]  mem_wdata_i
);

  import stream_pkg::*;

  logic               bank_req;
  logic [WORD_AW-1:0] bank_addr;
  logic               bank_gnt;
  logic               bank_r_valid;
  bank_word_t         bank_r_data;

  tcdm_source i_source (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .start_i        ( start_i        ),
    .base_i         ( base_i         ),
    .stride_i       ( stride_i       ),
    .len_i          ( len_i          ),
    .ready_start_o  ( ready_start_o  ),
    .done_o         ( done_o         ),
    .req_o          ( bank_req       ),
    .word_addr_o    ( bank_addr      ),
    .gnt_i          ( bank_gnt       ),
    .r_valid_i      ( bank_r_valid   ),
    .r_data_i       ( bank_r_data    ),
    .stream_valid_o ( stream_valid_o ),
    .stream_data_o  ( stream_data_o  ),
    .stream_ready_i ( stream_ready_i )
  );

  tcdm_bank i_bank (
    .clk_i       ( clk_i        ),
    .rst_ni      ( rst_ni       ),
    .req_i       ( bank_req     ),
    .word_addr_i ( bank_addr    ),
    .gnt_o       ( bank_gnt     ),
    .r_valid_o   ( bank_r_valid ),
    .r_data_o    ( bank_r_data  ),
    .we_i        ( mem_we_i     ),
    .waddr_i     ( mem_waddr_i  ),
    .wdata_i     ( mem_wdata_i  )
  );

endmodule

`default_nettype wire

// File: logic/stream_pkg.sv
// ======================================================================
// stream package
// widths, queue depths and shared types of the memory-to-stream
// read engine, used by the source, the bank and the top level
// ======================================================================
`default_nettype none

package stream_pkg;

  // byte address of a job and the word address seen by the bank
  localparam int ADDR_W  = 10;
  localparam int OFF_W   = 2;               // byte offset inside a 32-bit word
  localparam int WORD_AW = ADDR_W - OFF_W;

  localparam int DATA_W    = 32;
  localparam int MEM_WORDS = 256;           // bank depth in words

  // beat count of one job
  localparam int LEN_W = 8;

  // offsets in flight, at least the bank read latency plus one
  localparam int MIS_DEPTH = 2;

  localparam int ADDR_FIFO_DEPTH = 2;

  typedef enum logic [1:0] {
    IDLE,
    WORKING,
    DRAIN
  } streamer_state_t;

  // one bank read, two adjacent words
  typedef union packed {
    logic [1:0][DATA_W-1:0]        words;   // word view, filled by the bank
    logic [2*DATA_W/8-1:0][7:0]    bytes;   // byte view, used for realignment
  } bank_word_t;

endpackage

`default_nettype wire

// File: logic/sync_fifo.sv
// ======================================================================
// synchronous FIFO
// circular buffer with read/write pointers and an occupancy count,
// first-word view on data_o
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             empty_o,
  output logic             full_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop_i) rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;   // idle or push and pop together
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= data_i;
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o)
    else $error("push into a full FIFO");
  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o)
    else $error("pop from an empty FIFO");

endmodule

`default_nettype wire

// File: logic/tcdm_bank.sv
// ======================================================================
// scratchpad bank
// 32-bit words, one preload write port with priority over the read,
// and a read that returns two adjacent words one cycle after grant
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module tcdm_bank (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // read port
  input  logic                           req_i,
  input  logic [stream_pkg::WORD_AW-1:0] word_addr_i,
  output logic                           gnt_o,
  output logic                           r_valid_o,
  output stream_pkg::bank_word_t         r_data_o,
  // preload port
  input  logic                           we_i,
  input  logic [stream_pkg::WORD_AW-1:0] waddr_i,
  input  logic [stream_pkg::DATA_W-1:0]  wdata_i
);

  import stream_pkg::*;

  logic [DATA_W-1:0]  mem_q [MEM_WORDS];
  logic [WORD_AW-1:0] next_addr;

  // a write this cycle holds the read off
  assign gnt_o = req_i & ~we_i;

  // second word of the pair, wraps at the top of the bank
  assign next_addr = word_addr_i + WORD_AW'(1);

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_o <= 1'b0;
    end else begin
      r_valid_o <= gnt_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      r_data_o.words[0] <= mem_q[word_addr_i];
      r_data_o.words[1] <= mem_q[next_addr];   // bytes +4..+7
    end
  end

endmodule

`default_nettype wire

// File: logic/tcdm_source.sv
// ======================================================================
// scratchpad source streamer
// runs one strided read job: addresses go through a small FIFO to the
// bank, the byte offset of each granted request is queued, and every
// read word is realigned into a 32-bit valid/ready beat
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module tcdm_source (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // job
  input  logic                           start_i,
  input  logic [stream_pkg::ADDR_W-1:0]  base_i,
  input  logic [stream_pkg::ADDR_W-1:0]  stride_i,
  input  logic [stream_pkg::LEN_W-1:0]   len_i,
  output logic                           ready_start_o,
  output logic                           done_o,
  // bank
  output logic                           req_o,
  output logic [stream_pkg::WORD_AW-1:0] word_addr_o,
  input  logic                           gnt_i,
  input  logic                           r_valid_i,
  input  stream_pkg::bank_word_t         r_data_i,
  // output stream
  output logic                           stream_valid_o,
  output logic [stream_pkg::DATA_W-1:0]  stream_data_o,
  input  logic                           stream_ready_i
);

  import stream_pkg::*;

  streamer_state_t state_q;
  streamer_state_t state_d;

  logic [LEN_W-1:0]  len_q;
  logic [LEN_W-1:0]  beat_cnt_q;

  logic              gen_start;
  logic              gen_en;
  logic              gen_clr;
  logic [ADDR_W-1:0] gen_addr;
  logic              gen_valid;
  logic              gen_last;
  logic              gen_ready;

  logic              addr_push;
  logic [ADDR_W-1:0] addr_head;
  logic              addr_empty;
  logic              addr_full;
  logic              req_gnt;

  logic [OFF_W-1:0]  off_head;
  logic              off_empty;
  logic              off_full;
  logic              beat_acc;

  logic              hold_valid_q;
  bank_word_t        hold_data_q;
  bank_word_t        sel_word;

  assign ready_start_o = (state_q == IDLE);
  assign gen_start     = start_i & ready_start_o;   // starts mid-job are dropped
  assign done_o        = (state_q == DRAIN) & addr_empty & (beat_cnt_q == len_q);
  assign gen_clr       = done_o;
  assign gen_en        = ready_start_o ? gen_start : ~done_o;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (gen_start) state_d = WORKING;
      WORKING: if (gen_last) state_d = DRAIN;
      DRAIN:   if (done_o) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      beat_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (done_o) begin
        beat_cnt_q <= '0;
      end else if (beat_acc) begin
        beat_cnt_q <= beat_cnt_q + LEN_W'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gen_start) len_q <= len_i;
  end

  addr_gen i_addr_gen (
    .clk_i        ( clk_i     ),
    .rst_ni       ( rst_ni    ),
    .start_i      ( gen_start ),
    .en_i         ( gen_en    ),
    .clear_i      ( gen_clr   ),
    .base_i       ( base_i    ),
    .stride_i     ( stride_i  ),
    .len_i        ( len_i     ),
    .addr_o       ( gen_addr  ),
    .addr_valid_o ( gen_valid ),
    .last_o       ( gen_last  ),
    .addr_ready_i ( gen_ready )
  );

  assign gen_ready = ~addr_full & gen_en;
  assign addr_push = gen_valid & gen_ready;

  sync_fifo #(
    .WIDTH ( ADDR_W          ),
    .DEPTH ( ADDR_FIFO_DEPTH )
  ) i_addr_fifo (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .clear_i ( gen_clr    ),
    .push_i  ( addr_push  ),
    .data_i  ( gen_addr   ),
    .pop_i   ( req_gnt    ),
    .data_o  ( addr_head  ),
    .empty_o ( addr_empty ),
    .full_o  ( addr_full  )
  );

  // no new read while the stream is stalled
  assign req_o       = ~addr_empty & stream_ready_i;
  assign word_addr_o = addr_head[ADDR_W-1:OFF_W];
  assign req_gnt     = req_o & gnt_i;

  sync_fifo #(
    .WIDTH ( OFF_W     ),
    .DEPTH ( MIS_DEPTH )
  ) i_off_fifo (
    .clk_i   ( clk_i                 ),
    .rst_ni  ( rst_ni                ),
    .clear_i ( gen_clr               ),
    .push_i  ( req_gnt               ),
    .data_i  ( addr_head[OFF_W-1:0]  ),
    .pop_i   ( beat_acc              ),
    .data_o  ( off_head              ),
    .empty_o ( off_empty             ),
    .full_o  ( off_full              )
  );

  assign stream_valid_o = r_valid_i | hold_valid_q;
  assign beat_acc       = stream_valid_o & stream_ready_i;
  assign sel_word       = r_valid_i ? r_data_i : hold_data_q;   // live word wins

  // four bytes starting at the queued offset
  always_comb begin
    for (int b = 0; b < DATA_W/8; b++) begin
      stream_data_o[8*b +: 8] = sel_word.bytes[3'(off_head) + 3'(b)];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
    end else if (r_valid_i && !stream_ready_i) begin
      hold_valid_q <= 1'b1;
    end else if (stream_ready_i) begin
      hold_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (r_valid_i) hold_data_q <= r_data_i;
  end

  // each response matches a queued offset of a running job
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_i |-> (!off_empty && state_q != IDLE))
    else $error("read response without a queued offset");

  assert property (@(posedge clk_i) disable iff (!rst_ni) req_gnt |-> !off_full)
    else $error("offset queue overflow");

endmodule

`default_nettype wire

// File: sim.f
logic/stream_pkg.sv
logic/addr_gen.sv
logic/sync_fifo.sv
logic/tcdm_source.sv
logic/tcdm_bank.sv
logic/source_top.sv
dv/tb_source.sv
